/* filelist.f */
hw/rv32i_types.sv
hw/control_rom.sv
hw/regfile.sv
hw/alu.sv
hw/cmp.sv
hw/id_ex_if.sv
hw/id_stage.sv
hw/ex_stage.sv
hw/rv32i_core.sv
tb/rv32i_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST ?= filelist.f
TB_TOP ?= rv32i_core_tb
RTL_TOP ?= rv32i_core
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing -Wno-fatal

RTL_SRCS := $(filter hw/%,$(shell cat $(FILELIST)))

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only -Wall $(RTL_SRCS) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/rv32i_core_tb.sv */
`timescale 1ns/100ps

module rv32i_core_tb;

	localparam int reset_cycles = 16;
	localparam int n_seed = 62; // lui + addi for x1..x31
	localparam int n_rr = 64;
	localparam int n_imm = 64;
	localparam int n_dep = 48;
	localparam int n_jump = 40;
	localparam int n_br = 60;
	localparam int n_mem = 60;
	localparam int n_total = n_seed + n_rr + n_imm + n_dep + n_jump + n_br + n_mem;
	localparam int cycle_limit = 2 * n_total + reset_cycles;

	localparam logic [6:0] opc_lui = 7'b0110111;
	localparam logic [6:0] opc_auipc = 7'b0010111;
	localparam logic [6:0] opc_jal = 7'b1101111;
	localparam logic [6:0] opc_jalr = 7'b1100111;
	localparam logic [6:0] opc_br = 7'b1100011;
	localparam logic [6:0] opc_load = 7'b0000011;
	localparam logic [6:0] opc_store = 7'b0100011;
	localparam logic [6:0] opc_imm = 7'b0010011;
	localparam logic [6:0] opc_reg = 7'b0110011;
	localparam logic [6:0] opc_csr = 7'b1110011;

	typedef struct packed {
		logic [31:0] ins;
		logic [31:0] due; // cycle in which the result sits in execute
		logic wr;
		logic [4:0] rd;
		logic [31:0] data;
		logic redir;
		logic [31:0] target;
		logic mrd;
		logic mwr;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0] be;
	} expect_t;

	logic clk;
	logic reset;
	logic instr_valid;
	logic [31:0] instr;
	logic [31:0] pc;
	logic rd_write;
	logic [4:0] rd_addr;
	logic [31:0] rd_data;
	logic redirect;
	logic [31:0] redirect_target;
	logic mem_read;
	logic mem_write;
	logic [31:0] mem_address;
	logic [31:0] mem_wdata;
	logic [3:0] mem_byte_enable;

	integer seed = 32'hd304d007;
	logic [31:0] model_regs [32];
	logic [31:0] pc_cur;
	expect_t exp_q [$];
	int cycle = 0;
	int checks = 0;
	int errors = 0;
	int test_checks = 0;
	int test_errors = 0;

	rv32i_core uut (
		.clk(clk),
		.reset(reset),
		.instr_valid(instr_valid),
		.instr(instr),
		.pc(pc),
		.rd_write(rd_write),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.redirect(redirect),
		.redirect_target(redirect_target),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_address(mem_address),
		.mem_wdata(mem_wdata),
		.mem_byte_enable(mem_byte_enable)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] arith(input logic [2:0] f3, input logic sub_en,
		input logic sra_en, input logic [31:0] x, input logic [31:0] y);
		case (f3)
			3'd0: return sub_en ? x - y : x + y;
			3'd1: return x << y[4:0];
			3'd2: return {31'd0, $signed(x) < $signed(y)};
			3'd3: return {31'd0, x < y};
			3'd4: return x ^ y;
			3'd5: begin
				if (sra_en) begin
					return $signed(x) >>> y[4:0];
				end
				return x >> y[4:0];
			end
			3'd6: return x | y;
			default: return x & y;
		endcase
	endfunction

	function automatic logic taken(input logic [2:0] f3, input logic [31:0] x,
		input logic [31:0] y);
		case (f3)
			3'd0: return x == y;
			3'd1: return x != y;
			3'd4: return $signed(x) < $signed(y);
			3'd5: return $signed(x) >= $signed(y);
			3'd6: return x < y;
			3'd7: return x >= y;
			default: return 1'b0;
		endcase
	endfunction

	// reference model of one instruction against the model register file
	function automatic expect_t predict(input logic [31:0] ins, input logic [31:0] ipc);
		expect_t e;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [31:0] imm_u;
		logic [31:0] imm_j;
		e = '0;
		a = model_regs[ins[19:15]];
		b = model_regs[ins[24:20]];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
		imm_u = {ins[31:12], 12'd0};
		imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
		e.ins = ins;
		e.rd = ins[11:7];
		case (ins[6:0])
			opc_lui: begin
				e.wr = 1'b1;
				e.data = imm_u;
			end
			opc_auipc: begin
				e.wr = 1'b1;
				e.data = ipc + imm_u;
			end
			opc_jal: begin
				e.wr = 1'b1;
				e.data = ipc + 32'd4;
				e.redir = 1'b1;
				e.target = ipc + imm_j;
			end
			opc_jalr: begin
				e.wr = 1'b1;
				e.data = ipc + 32'd4;
				e.redir = 1'b1;
				e.target = (a + imm_i) & ~32'd1;
			end
			opc_br: begin
				e.redir = taken(ins[14:12], a, b);
				e.target = ipc + imm_b;
			end
			opc_load: begin
				e.mrd = 1'b1;
				e.addr = a + imm_i;
			end
			opc_store: begin
				e.mwr = 1'b1;
				e.addr = a + imm_s;
				case (ins[14:12])
					3'd0: begin
						e.be = 4'b0000;
						e.be[e.addr[1:0]] = 1'b1; // one lane picked by the low address bits
						e.wdata = {4{b[7:0]}};
					end
					3'd1: begin
						e.be = e.addr[1] ? 4'b1100 : 4'b0011; // halfword lane from bit 1
						e.wdata = e.addr[1] ? {b[15:0], 16'd0} : b;
					end
					default: begin
						e.be = 4'b1111;
						e.wdata = b;
					end
				endcase
			end
			opc_imm: begin
				e.wr = 1'b1;
				e.data = arith(ins[14:12], 1'b0, ins[30], a, imm_i);
			end
			opc_reg: begin
				e.wr = 1'b1;
				e.data = arith(ins[14:12], ins[30], ins[30], a, b);
			end
			default: begin
				e.wr = 1'b0; // unknown opcodes do nothing
			end
		endcase
		return e;
	endfunction

	function automatic logic known_opcode(input logic [6:0] opc);
		return opc inside {opc_lui, opc_auipc, opc_jal, opc_jalr, opc_br, opc_load,
			opc_store, opc_imm, opc_reg};
	endfunction

	function automatic logic [31:0] alu_instr(input logic reg_form);
		logic [31:0] ins;
		ins = $random(seed);
		if (reg_form) begin
			ins[6:0] = opc_reg;
			ins[31:25] = ((ins[14:12] == 3'd0 || ins[14:12] == 3'd5) && ins[30]) ?
				7'b0100000 : 7'd0;
		end else begin
			ins[6:0] = opc_imm;
			if (ins[13:12] == 2'b01) begin
				ins[31:25] = (ins[14] && ins[30]) ? 7'b0100000 : 7'd0; // slli, srli, srai
			end
		end
		return ins;
	endfunction

	task automatic note_error(input string msg);
		$display("FAILED at time %0t: %s", $time, msg);
		errors++;
		test_errors++;
	endtask

	task automatic compare_outputs(input expect_t e);
		logic [31:0] mask;
		mask = {{8{e.be[3]}}, {8{e.be[2]}}, {8{e.be[1]}}, {8{e.be[0]}}};
		checks++;
		test_checks++;
		if (rd_write !== e.wr) begin
			note_error($sformatf("instr %h rd_write is %b, expected %b", e.ins, rd_write, e.wr));
		end
		if (e.wr && (rd_addr !== e.rd || rd_data !== e.data)) begin
			note_error($sformatf("instr %h writes x%0d = %h, expected x%0d = %h",
				e.ins, rd_addr, rd_data, e.rd, e.data));
		end
		if (redirect !== e.redir) begin
			note_error($sformatf("instr %h redirect is %b, expected %b", e.ins, redirect, e.redir));
		end
		if (e.redir && redirect_target !== e.target) begin
			note_error($sformatf("instr %h target is %h, expected %h",
				e.ins, redirect_target, e.target));
		end
		if (mem_read !== e.mrd || mem_write !== e.mwr) begin
			note_error($sformatf("instr %h read/write is %b%b, expected %b%b",
				e.ins, mem_read, mem_write, e.mrd, e.mwr));
		end
		if ((e.mrd || e.mwr) && mem_address !== e.addr) begin
			note_error($sformatf("instr %h address is %h, expected %h", e.ins, mem_address, e.addr));
		end
		if (e.mwr && mem_byte_enable !== e.be) begin
			note_error($sformatf("instr %h byte enable is %b, expected %b",
				e.ins, mem_byte_enable, e.be));
		end
		if (e.mwr && (mem_wdata & mask) !== (e.wdata & mask)) begin
			note_error($sformatf("instr %h store data is %h, expected %h",
				e.ins, mem_wdata & mask, e.wdata & mask));
		end
	endtask

	// one instruction per cycle, result due in the following cycle
	task automatic issue(input logic [31:0] ins);
		expect_t e;
		@(posedge clk);
		#10;
		e = predict(ins, pc_cur);
		e.due = cycle + 1;
		exp_q.push_back(e);
		if (e.wr && e.rd != 5'd0) begin
			model_regs[e.rd] = e.data;
		end
		instr_valid = 1'b1;
		instr = ins;
		pc = pc_cur;
		pc_cur = pc_cur + 32'd4;
	endtask

	task automatic end_test(input string name);
		@(posedge clk);
		#10;
		instr_valid = 1'b0;
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
		$display("test %s finished: %0d checked, %0d errors", name, test_checks, test_errors);
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic seed_regs();
		logic [31:0] v;
		for (int r = 1; r < 32; r++) begin
			v = $random(seed);
			issue({v[31:12], r[4:0], opc_lui});
			issue({v[11:0], r[4:0], 3'b000, r[4:0], opc_imm});
		end
	endtask

	task automatic run_dependencies();
		logic [31:0] ins;
		logic [4:0] prev_rd;
		prev_rd = 5'd1;
		for (int i = 0; i < n_dep; i++) begin
			ins = alu_instr(i[0]);
			ins[19:15] = prev_rd; // reads the result of the previous cycle
			if (i % 4 == 3) begin
				ins[11:7] = 5'd0;
			end
			issue(ins);
			prev_rd = ins[11:7];
		end
		end_test("back-to-back");
	endtask

	task automatic run_jumps();
		logic [31:0] ins;
		for (int i = 0; i < n_jump; i++) begin
			ins = $random(seed);
			case (i % 4)
				0: ins[6:0] = opc_lui;
				1: ins[6:0] = opc_auipc;
				2: ins[6:0] = opc_jal;
				default: begin
					ins[6:0] = opc_jalr;
					ins[14:12] = 3'd0;
				end
			endcase
			issue(ins);
		end
		end_test("upper-immediate and jump");
	endtask

	task automatic run_branches();
		logic [31:0] ins;
		for (int i = 0; i < n_br; i++) begin
			ins = $random(seed);
			ins[6:0] = opc_br;
			if (ins[14:13] == 2'b01) begin
				ins[14] = 1'b1; // funct3 2 and 3 are not branches
			end
			if (i % 3 == 0) begin
				ins[24:20] = ins[19:15];
			end
			issue(ins);
		end
		end_test("branch");
	endtask

	task automatic run_memory();
		logic [31:0] ins;
		logic [31:0] v;
		for (int i = 0; i < n_mem; i++) begin
			ins = $random(seed);
			if (i < 20) begin
				ins[6:0] = opc_load;
				if (ins[13:12] == 2'b11 || ins[14:13] == 2'b11) begin
					ins[14:12] = 3'd2;
				end
			end else if (i < 50) begin
				ins[6:0] = opc_store;
				ins[14:12] = 3'(i % 3);
			end else if (i == 50) begin
				ins[6:0] = opc_csr;
			end else begin
				while (known_opcode(ins[6:0])) begin
					v = $random(seed);
					ins[6:0] = v[6:0];
				end
			end
			issue(ins);
		end
		end_test("memory and illegal");
	endtask

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= cycle_limit) begin
			$display("timeout: run stopped after %0d cycles with results outstanding", cycle);
			$display("tests done: %0d checked, %0d errors", checks, errors);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	always @(negedge clk) begin
		expect_t e;
		if (!reset) begin
			if (exp_q.size() != 0 && exp_q[0].due == cycle) begin
				e = exp_q.pop_front();
				compare_outputs(e);
			end else if (rd_write || redirect || mem_read || mem_write) begin
				note_error("outputs active with no instruction in execute");
			end
		end
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		pc = '0;
		pc_cur = 32'h0000_1000;
		for (int r = 0; r < 32; r++) begin
			model_regs[r] = '0;
		end
		repeat (reset_cycles) @(posedge clk);
		#10;
		reset = 1'b0;

		seed_regs();
		for (int i = 0; i < n_rr; i++) begin
			issue(alu_instr(1'b1));
		end
		end_test("register-register");
		for (int i = 0; i < n_imm; i++) begin
			issue(alu_instr(1'b0));
		end
		end_test("immediate");
		run_dependencies();
		run_jumps();
		run_branches();
		run_memory();

		$display("tests done: %0d checked, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule : rv32i_core_tb

/* hw/rv32i_core.sv */
`timescale 1ns/100ps

module rv32i_core (
	input logic clk,
	input logic reset,
	input logic instr_valid,
	input rv32i_types::rv32i_word instr,
	input rv32i_types::rv32i_word pc,
	output logic rd_write,
	output rv32i_types::rv32i_reg rd_addr,
	output rv32i_types::rv32i_word rd_data,
	output logic redirect,
	output rv32i_types::rv32i_word redirect_target,
	output logic mem_read,
	output logic mem_write,
	output rv32i_types::rv32i_word mem_address,
	output rv32i_types::rv32i_word mem_wdata,
	output logic [3:0] mem_byte_enable
);

	id_ex_if id_ex ();

	id_stage u_id_stage (
		.clk(clk),
		.reset(reset),
		.instr_valid(instr_valid),
		.instr(instr),
		.pc(pc),
		.rd_write(rd_write), // writeback loops back into the regfile
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.ex(id_ex.id)
	);

	ex_stage u_ex_stage (
		.id(id_ex.ex),
		.rd_write(rd_write),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.redirect(redirect),
		.redirect_target(redirect_target),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_address(mem_address),
		.mem_wdata(mem_wdata),
		.mem_byte_enable(mem_byte_enable)
	);

endmodule : rv32i_core

/* hw/ex_stage.sv */
`timescale 1ns/100ps

module ex_stage (
	id_ex_if.ex id,
	output logic rd_write,
	output rv32i_types::rv32i_reg rd_addr,
	output rv32i_types::rv32i_word rd_data,
	output logic redirect,
	output rv32i_types::rv32i_word redirect_target,
	output logic mem_read,
	output logic mem_write,
	output rv32i_types::rv32i_word mem_address,
	output rv32i_types::rv32i_word mem_wdata,
	output logic [3:0] mem_byte_enable
);

	rv32i_types::rv32i_word alu_a;
	rv32i_types::rv32i_word alu_b;
	rv32i_types::rv32i_word alu_f;
	rv32i_types::rv32i_word cmp_b;
	logic br_en;
	logic is_store;
	logic [3:0] store_be;

	assign alu_a = id.ctrl.alumux1_sel ? id.pc : id.rs1_data;
	assign cmp_b = id.ctrl.cmpmux_sel ? id.i_imm : id.rs2_data;

	always_comb begin
		case (id.ctrl.alumux2_sel)
			3'd1: alu_b = id.u_imm;
			3'd2: alu_b = id.b_imm;
			3'd3: alu_b = id.s_imm;
			3'd4: alu_b = id.rs2_data;
			3'd5: alu_b = id.j_imm;
			default: alu_b = id.i_imm;
		endcase
	end

	alu u_alu (.aluop(id.ctrl.aluop), .a(alu_a), .b(alu_b), .f(alu_f));
	cmp u_cmp (.cmpop(id.ctrl.cmpop), .a(id.rs1_data), .b(cmp_b), .br_en(br_en));

	always_comb begin
		case (id.ctrl.regfilemux_sel)
			3'd1: rd_data = {31'd0, br_en}; // slt and sltu
			3'd2: rd_data = id.u_imm;
			3'd4: rd_data = id.pc + 32'd4;
			default: rd_data = alu_f;
		endcase
	end

	assign rd_write = id.valid & id.ctrl.load_regfile;
	assign rd_addr = id.rd;

	assign redirect = id.valid & (id.ctrl.pcmux_sel |
		(id.ctrl.opcode == rv32i_types::op_br && br_en));
	assign redirect_target = {alu_f[31:1],
		alu_f[0] & (id.ctrl.opcode != rv32i_types::op_jalr)};

	assign is_store = (id.ctrl.opcode == rv32i_types::op_store);
	assign mem_read = id.valid & (id.ctrl.opcode == rv32i_types::op_load);
	assign mem_write = id.valid & is_store;
	assign mem_address = alu_f;

	always_comb begin
		case (rv32i_types::store_funct3_t'(id.ctrl.funct3))
			rv32i_types::sb: begin
				store_be = 4'b0001 << alu_f[1:0];
				mem_wdata = id.rs2_data << {alu_f[1:0], 3'b000};
			end
			rv32i_types::sh: begin
				store_be = 4'b0011 << {alu_f[1], 1'b0};
				mem_wdata = id.rs2_data << {alu_f[1], 4'b0000};
			end
			rv32i_types::sw: begin
				store_be = 4'b1111;
				mem_wdata = id.rs2_data;
			end
			default: begin
				store_be = 4'b0000; // no such store width
				mem_wdata = id.rs2_data;
			end
		endcase
	end

	assign mem_byte_enable = is_store ? (id.ctrl.mem_byte_enable & store_be)
		: id.ctrl.mem_byte_enable;

endmodule : ex_stage

/* hw/id_stage.sv */
`timescale 1ns/100ps

module id_stage (
	input logic clk,
	input logic reset,
	input logic instr_valid,
	input rv32i_types::rv32i_word instr,
	input rv32i_types::rv32i_word pc,
	input logic rd_write,
	input rv32i_types::rv32i_reg rd_addr,
	input rv32i_types::rv32i_word rd_data,
	id_ex_if.id ex
);

	rv32i_types::rv32i_control_word ctrl;
	rv32i_types::rv32i_word rs1_data;
	rv32i_types::rv32i_word rs2_data;
	rv32i_types::rv32i_word i_imm;
	rv32i_types::rv32i_word s_imm;
	rv32i_types::rv32i_word b_imm;
	rv32i_types::rv32i_word u_imm;
	rv32i_types::rv32i_word j_imm;

	assign i_imm = {{21{instr[31]}}, instr[30:20]};
	assign s_imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
	assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign u_imm = {instr[31:12], 12'h000};
	assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	control_rom u_control_rom (
		.opcode(rv32i_types::rv32i_opcode'(instr[6:0])),
		.funct3(instr[14:12]),
		.funct7(instr[31:25]),
		.ctrl(ctrl)
	);

	regfile u_regfile (
		.clk(clk),
		.reset(reset),
		.load(rd_write),
		.rd(rd_addr),
		.in(rd_data),
		.rs1(instr[19:15]),
		.rs2(instr[24:20]),
		.rs1_out(rs1_data),
		.rs2_out(rs2_data)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			ex.valid <= 1'b0;
		end else begin
			ex.valid <= instr_valid; // one cycle in execute, then drops
		end
	end

	always_ff @(posedge clk) begin
		if (instr_valid) begin
			ex.ctrl <= ctrl;
			ex.pc <= pc;
			ex.rs1_data <= rs1_data;
			ex.rs2_data <= rs2_data;
			ex.rd <= instr[11:7];
			ex.i_imm <= i_imm;
			ex.s_imm <= s_imm;
			ex.b_imm <= b_imm;
			ex.u_imm <= u_imm;
			ex.j_imm <= j_imm;
		end
	end

endmodule : id_stage

/* hw/id_ex_if.sv */
`timescale 1ns/100ps

interface id_ex_if;

	logic valid; // qualifies all other fields
	rv32i_types::rv32i_control_word ctrl;
	rv32i_types::rv32i_word pc;
	rv32i_types::rv32i_word rs1_data;
	rv32i_types::rv32i_word rs2_data;
	rv32i_types::rv32i_reg rd;
	rv32i_types::rv32i_word i_imm;
	rv32i_types::rv32i_word s_imm;
	rv32i_types::rv32i_word b_imm;
	rv32i_types::rv32i_word u_imm;
	rv32i_types::rv32i_word j_imm;

	modport id (
		output valid, ctrl, pc, rs1_data, rs2_data, rd,
		output i_imm, s_imm, b_imm, u_imm, j_imm
	);

	modport ex (
		input valid, ctrl, pc, rs1_data, rs2_data, rd,
		input i_imm, s_imm, b_imm, u_imm, j_imm
	);

endinterface : id_ex_if

/* hw/cmp.sv */
`timescale 1ns/100ps

module cmp (
	input rv32i_types::branch_funct3_t cmpop,
	input rv32i_types::rv32i_word a,
	input rv32i_types::rv32i_word b,
	output logic br_en
);

	always_comb begin
		case (cmpop)
			rv32i_types::beq:  br_en = (a == b);
			rv32i_types::bne:  br_en = (a != b);
			rv32i_types::blt:  br_en = ($signed(a) < $signed(b));
			rv32i_types::bge:  br_en = ($signed(a) >= $signed(b));
			rv32i_types::bltu: br_en = (a < b);
			rv32i_types::bgeu: br_en = (a >= b);
			default: br_en = 1'b0; // codes 2 and 3 never branch
		endcase
	end

endmodule : cmp

/* hw/alu.sv */
`timescale 1ns/100ps

module alu (
	input rv32i_types::alu_ops aluop,
	input rv32i_types::rv32i_word a,
	input rv32i_types::rv32i_word b,
	output rv32i_types::rv32i_word f
);

	always_comb begin
		case (aluop)
			rv32i_types::alu_add: f = a + b;
			rv32i_types::alu_sll: f = a << b[4:0];
			rv32i_types::alu_sra: f = $unsigned($signed(a) >>> b[4:0]);
			rv32i_types::alu_sub: f = a - b;
			rv32i_types::alu_xor: f = a ^ b;
			rv32i_types::alu_srl: f = a >> b[4:0];
			rv32i_types::alu_or:  f = a | b;
			rv32i_types::alu_and: f = a & b;
			default: f = '0;
		endcase
	end

endmodule : alu

/* hw/regfile.sv */
`timescale 1ns/100ps

module regfile (
	input logic clk,
	input logic reset,
	input logic load,
	input rv32i_types::rv32i_reg rd,
	input rv32i_types::rv32i_word in,
	input rv32i_types::rv32i_reg rs1,
	input rv32i_types::rv32i_reg rs2,
	output rv32i_types::rv32i_word rs1_out,
	output rv32i_types::rv32i_word rs2_out
);

	rv32i_types::rv32i_word data [1:rv32i_types::num_regs-1]; // x0 has no storage

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < rv32i_types::num_regs; i++) begin
				data[i] <= '0;
			end
		end else if (load && rd != 5'd0) begin
			data[rd] <= in;
		end
	end

	// same-cycle write is forwarded so back-to-back issue needs no stall
	assign rs1_out = (rs1 == 5'd0) ? '0 : (load && rd == rs1) ? in : data[rs1];
	assign rs2_out = (rs2 == 5'd0) ? '0 : (load && rd == rs2) ? in : data[rs2];

endmodule : regfile

/* hw/control_rom.sv */
`timescale 1ns/100ps

module control_rom (
	input rv32i_types::rv32i_opcode opcode,
	input logic [2:0] funct3,
	input logic [6:0] funct7,
	output rv32i_types::rv32i_control_word ctrl
);

	always_comb begin
		ctrl.opcode = opcode;
		ctrl.funct3 = funct3;
		ctrl.load_regfile = 1'b0;
		ctrl.aluop = rv32i_types::alu_ops'(funct3); // funct3 doubles as alu code
		ctrl.cmpop = rv32i_types::branch_funct3_t'(funct3);
		ctrl.mem_byte_enable = 4'b1111;
		ctrl.regfilemux_sel = 3'd0;
		ctrl.pcmux_sel = 1'b0;
		ctrl.alumux1_sel = 1'b0;
		ctrl.alumux2_sel = 3'd0;
		ctrl.cmpmux_sel = 1'b0;

		case (opcode)
			rv32i_types::op_lui: begin
				ctrl.load_regfile = 1'b1;
				ctrl.regfilemux_sel = 3'd2; // u_imm straight through
			end
			rv32i_types::op_auipc: begin
				ctrl.load_regfile = 1'b1;
				ctrl.aluop = rv32i_types::alu_add;
				ctrl.alumux1_sel = 1'b1; // pc + u_imm
				ctrl.alumux2_sel = 3'd1;
			end
			rv32i_types::op_jal: begin
				ctrl.load_regfile = 1'b1;
				ctrl.regfilemux_sel = 3'd4; // link value
				ctrl.pcmux_sel = 1'b1;
				ctrl.aluop = rv32i_types::alu_add;
				ctrl.alumux1_sel = 1'b1;
				ctrl.alumux2_sel = 3'd5;
			end
			rv32i_types::op_jalr: begin
				ctrl.load_regfile = 1'b1;
				ctrl.regfilemux_sel = 3'd4;
				ctrl.pcmux_sel = 1'b1;
				ctrl.aluop = rv32i_types::alu_add; // rs1 + i_imm
			end
			rv32i_types::op_br: begin
				ctrl.aluop = rv32i_types::alu_add;
				ctrl.alumux1_sel = 1'b1; // target is pc + b_imm
				ctrl.alumux2_sel = 3'd2;
			end
			rv32i_types::op_load: begin
				ctrl.aluop = rv32i_types::alu_add; // address only, no writeback
			end
			rv32i_types::op_store: begin
				ctrl.aluop = rv32i_types::alu_add;
				ctrl.alumux2_sel = 3'd3;
			end
			rv32i_types::op_imm, rv32i_types::op_reg: begin
				ctrl.load_regfile = 1'b1;
				if (opcode == rv32i_types::op_reg) begin
					ctrl.alumux2_sel = 3'd4;
				end
				case (rv32i_types::arith_funct3_t'(funct3))
					rv32i_types::add: begin
						// only the register form has sub
						if (opcode == rv32i_types::op_reg &&
							funct7 == rv32i_types::funct7_alt) begin
							ctrl.aluop = rv32i_types::alu_sub;
						end
					end
					rv32i_types::slt: begin
						ctrl.cmpop = rv32i_types::blt;
						ctrl.regfilemux_sel = 3'd1;
						ctrl.cmpmux_sel = (opcode == rv32i_types::op_imm);
					end
					rv32i_types::sltu: begin
						ctrl.cmpop = rv32i_types::bltu;
						ctrl.regfilemux_sel = 3'd1;
						ctrl.cmpmux_sel = (opcode == rv32i_types::op_imm);
					end
					rv32i_types::sr: begin
						if (funct7 == rv32i_types::funct7_alt) begin
							ctrl.aluop = rv32i_types::alu_sra;
						end else begin
							ctrl.aluop = rv32i_types::alu_srl;
						end
					end
					default: begin
						ctrl.aluop = rv32i_types::alu_ops'(funct3);
					end
				endcase
			end
			rv32i_types::op_csr: begin
				ctrl = '0; // system instructions are not executed
			end
			default: begin
				ctrl = '0;
			end
		endcase
	end

endmodule : control_rom

/* hw/rv32i_types.sv */
package rv32i_types;

	localparam int unsigned word_width = 32;
	localparam int unsigned num_regs = 32;
	localparam logic [6:0] funct7_alt = 7'b0100000; // selects sub and sra

	typedef logic [word_width-1:0] rv32i_word;
	typedef logic [4:0] rv32i_reg;
	typedef logic [2:0] regfilemux_sel_t; // 0 alu, 1 br_en, 2 u_imm, 3 load, 4 pc+4
	typedef logic [2:0] alumux2_sel_t; // 0 i, 1 u, 2 b, 3 s, 4 rs2, 5 j

	typedef enum logic [6:0] {
		op_lui   = 7'b0110111,
		op_auipc = 7'b0010111,
		op_jal   = 7'b1101111,
		op_jalr  = 7'b1100111,
		op_br    = 7'b1100011,
		op_load  = 7'b0000011,
		op_store = 7'b0100011,
		op_imm   = 7'b0010011,
		op_reg   = 7'b0110011,
		op_csr   = 7'b1110011
	} rv32i_opcode;

	typedef enum logic [2:0] {
		alu_add = 3'b000,
		alu_sll = 3'b001,
		alu_sra = 3'b010,
		alu_sub = 3'b011,
		alu_xor = 3'b100,
		alu_srl = 3'b101,
		alu_or  = 3'b110,
		alu_and = 3'b111
	} alu_ops;

	typedef enum logic [2:0] {
		beq  = 3'b000,
		bne  = 3'b001,
		blt  = 3'b100,
		bge  = 3'b101,
		bltu = 3'b110,
		bgeu = 3'b111
	} branch_funct3_t;

	typedef enum logic [2:0] {
		add  = 3'b000,
		sll  = 3'b001,
		slt  = 3'b010,
		sltu = 3'b011,
		axor = 3'b100,
		sr   = 3'b101,
		aor  = 3'b110,
		aand = 3'b111
	} arith_funct3_t;

	typedef enum logic [2:0] {
		sb = 3'b000,
		sh = 3'b001,
		sw = 3'b010
	} store_funct3_t;

	typedef struct packed {
		rv32i_opcode opcode;
		logic [2:0] funct3; // kept for store alignment
		logic load_regfile;
		alu_ops aluop;
		branch_funct3_t cmpop;
		logic [3:0] mem_byte_enable;
		regfilemux_sel_t regfilemux_sel;
		logic pcmux_sel; // jal and jalr always redirect
		logic alumux1_sel; // 0 rs1, 1 pc
		alumux2_sel_t alumux2_sel;
		logic cmpmux_sel; // 0 rs2, 1 i_imm
	} rv32i_control_word;

endpackage : rv32i_types
